// ==== mips_isa_pkg.sv ====
// mips opcode, funct, regimm and cp0 constants; instruction word union with r, i and j views
package mips_isa_pkg;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_cop0    = 6'h10;

    // loads and stores
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lh      = 6'h21;
    localparam logic [5:0] op_lwl     = 6'h22;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_lhu     = 6'h25;
    localparam logic [5:0] op_lwr     = 6'h26;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sh      = 6'h29;
    localparam logic [5:0] op_swl     = 6'h2a;
    localparam logic [5:0] op_sw      = 6'h2b;
    localparam logic [5:0] op_swr     = 6'h2e;

    // SPECIAL function codes
    localparam logic [5:0] funct_sll  = 6'h00;
    localparam logic [5:0] funct_srl  = 6'h02;
    localparam logic [5:0] funct_sra  = 6'h03;
    localparam logic [5:0] funct_jr   = 6'h08;
    localparam logic [5:0] funct_jalr = 6'h09;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_xor  = 6'h26;
    localparam logic [5:0] funct_nor  = 6'h27;
    localparam logic [5:0] funct_slt  = 6'h2a;
    localparam logic [5:0] funct_sltu = 6'h2b;

    // REGIMM codes carried in rt
    localparam logic [4:0] regimm_bltz = 5'h00;
    localparam logic [4:0] regimm_bgez = 5'h01;

    // cp0 rs sub-codes, then CO function codes
    localparam logic [4:0] cop0_mf    = 5'h00;
    localparam logic [4:0] cop0_mt    = 5'h04;
    localparam logic [5:0] cop0_tlbwi = 6'h02;
    localparam logic [5:0] cop0_tlbp  = 6'h08;
    localparam logic [5:0] cop0_eret  = 6'h18;
    localparam logic [5:0] cop0_wait  = 6'h20;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } inst_word_t;

endpackage

// ==== decode_pkg.sv ====
// instruction identifier and immediate kind enumerations, decoder and record structs
package decode_pkg;

    // width of the immediate held in the decoded record
    localparam int imm_w = 32;

    typedef enum logic [7:0] {
        inst_invalid = 8'd0,
        // R-type
        inst_sll, inst_srl, inst_sra, inst_jr, inst_jalr,
        inst_addu, inst_subu, inst_and, inst_or, inst_xor, inst_nor, inst_slt, inst_sltu,
        // I-type branches and ALU immediates
        inst_bltz, inst_bgez, inst_beq, inst_bne, inst_blez, inst_bgtz,
        inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui,
        // cp0
        inst_mfc0, inst_mtc0, inst_tlbwi, inst_tlbp, inst_eret, inst_wait,
        // memory
        inst_lb, inst_lh, inst_lwl, inst_lw, inst_lbu, inst_lhu, inst_lwr,
        inst_sb, inst_sh, inst_swl, inst_sw, inst_swr,
        // J-type
        inst_j, inst_jal
    } inst_id_t;

    typedef enum logic [1:0] {
        imm_sign  = 2'd0,
        imm_zero  = 2'd1,
        imm_upper = 2'd2
    } imm_kind_t;

    // output of one field decoder
    typedef struct packed {
        inst_id_t    inst;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [15:0] imm16;
        imm_kind_t   imm_kind;
    } part_dec_t;

    // registered record leaving the stage
    typedef struct packed {
        inst_id_t         inst;
        logic [4:0]       rs;
        logic [4:0]       rt;
        logic [4:0]       rd;
        logic [4:0]       shamt;
        logic [imm_w-1:0] imm;
    } dec_t;

endpackage

// ==== id_i.sv ====
// I-type and cp0 decoder producing identifier, rs, rt, rd and raw immediate
`timescale 1ns/1ps

module id_i (
    input  mips_isa_pkg::inst_word_t inst_code,
    output decode_pkg::part_dec_t    i_dec
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    inst_id_t  inst;
    imm_kind_t kind;
    logic      use_rs;
    logic      use_rt;
    logic      use_rd;
    logic      use_imm;

    always_comb
    begin
        inst    = inst_invalid;
        kind    = imm_sign;
        use_rs  = 1'b1;
        use_rt  = 1'b1;
        use_rd  = 1'b0;
        use_imm = 1'b1;
        case (inst_code.i.opcode)
            op_regimm:
            begin
                // rt selects the condition here
                use_rt = 1'b0;
                case (inst_code.i.rt)
                    regimm_bltz: inst = inst_bltz;
                    regimm_bgez: inst = inst_bgez;
                    default:     inst = inst_invalid;
                endcase
            end
            op_beq:   inst = inst_beq;
            op_bne:   inst = inst_bne;
            op_blez:
            begin
                inst   = inst_blez;
                use_rt = 1'b0;
            end
            op_bgtz:
            begin
                inst   = inst_bgtz;
                use_rt = 1'b0;
            end
            op_addiu: inst = inst_addiu;
            op_slti:  inst = inst_slti;
            op_sltiu: inst = inst_sltiu;
            op_andi:
            begin
                inst = inst_andi;
                kind = imm_zero;
            end
            op_ori:
            begin
                inst = inst_ori;
                kind = imm_zero;
            end
            op_xori:
            begin
                inst = inst_xori;
                kind = imm_zero;
            end
            op_lui:
            begin
                inst   = inst_lui;
                kind   = imm_upper;
                use_rs = 1'b0;
            end
            op_cop0:
            begin
                use_imm = 1'b0;
                use_rs  = 1'b0;
                if (inst_code.i.rs == cop0_mf || inst_code.i.rs == cop0_mt)
                begin
                    // rd names the cp0 register
                    inst   = (inst_code.i.rs == cop0_mf) ? inst_mfc0 : inst_mtc0;
                    use_rd = 1'b1;
                end
                else if (inst_code.i.rs[4])
                begin
                    use_rt = 1'b0;
                    case (inst_code.r.funct)
                        cop0_tlbwi: inst = inst_tlbwi;
                        cop0_tlbp:  inst = inst_tlbp;
                        cop0_eret:  inst = inst_eret;
                        cop0_wait:  inst = inst_wait;
                        default:    inst = inst_invalid;
                    endcase
                end
            end
            op_lb:    inst = inst_lb;
            op_lh:    inst = inst_lh;
            op_lwl:   inst = inst_lwl;
            op_lw:    inst = inst_lw;
            op_lbu:   inst = inst_lbu;
            op_lhu:   inst = inst_lhu;
            op_lwr:   inst = inst_lwr;
            op_sb:    inst = inst_sb;
            op_sh:    inst = inst_sh;
            op_swl:   inst = inst_swl;
            op_sw:    inst = inst_sw;
            op_swr:   inst = inst_swr;
            default:  inst = inst_invalid;
        endcase
    end

    // unused fields and invalid words leave zeros
    always_comb
    begin
        i_dec      = '0;
        i_dec.inst = inst;
        if (inst != inst_invalid)
        begin
            if (use_rs)
                i_dec.rs = inst_code.i.rs;
            if (use_rt)
                i_dec.rt = inst_code.i.rt;
            if (use_rd)
                i_dec.rd = inst_code.r.rd;
            if (use_imm)
            begin
                i_dec.imm16    = inst_code.i.imm16;
                i_dec.imm_kind = kind;
            end
        end
    end

    // any fully known word maps to a defined identifier
    always_comb
    begin
        if (!$isunknown(inst_code))
            a_inst_known: assert final (!$isunknown(i_dec.inst));
    end

endmodule

// ==== id_r.sv ====
// SPECIAL decoder with funct lookup and zero-field checks
`timescale 1ns/1ps

module id_r (
    input  mips_isa_pkg::inst_word_t inst_code,
    output decode_pkg::part_dec_t    r_dec
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    inst_id_t inst;
    inst_id_t inst_ok;
    logic     rule_ok;
    logic     use_rs;
    logic     use_rt;
    logic     use_rd;
    logic     use_sa;

    always_comb
    begin
        inst    = inst_invalid;
        use_rs  = 1'b1;
        use_rt  = 1'b1;
        use_rd  = 1'b1;
        use_sa  = 1'b0;
        // most functions need a zero shamt
        rule_ok = (inst_code.r.shamt == 5'd0);
        case (inst_code.r.funct)
            funct_sll, funct_srl, funct_sra:
            begin
                case (inst_code.r.funct)
                    funct_sll: inst = inst_sll;
                    funct_srl: inst = inst_srl;
                    default:   inst = inst_sra;
                endcase
                use_rs  = 1'b0;
                use_sa  = 1'b1;
                rule_ok = (inst_code.r.rs == 5'd0);
            end
            funct_jr:
            begin
                inst    = inst_jr;
                use_rt  = 1'b0;
                use_rd  = 1'b0;
                rule_ok = rule_ok && inst_code.r.rt == 5'd0 && inst_code.r.rd == 5'd0;
            end
            funct_jalr:
            begin
                inst   = inst_jalr;
                use_rt = 1'b0;
            end
            funct_addu: inst = inst_addu;
            funct_subu: inst = inst_subu;
            funct_and:  inst = inst_and;
            funct_or:   inst = inst_or;
            funct_xor:  inst = inst_xor;
            funct_nor:  inst = inst_nor;
            funct_slt:  inst = inst_slt;
            funct_sltu: inst = inst_sltu;
            default:    inst = inst_invalid;
        endcase
    end

    assign inst_ok = rule_ok ? inst : inst_invalid;

    // R-type carries no immediate
    always_comb
    begin
        r_dec      = '0;
        r_dec.inst = inst_ok;
        if (inst_ok != inst_invalid)
        begin
            if (use_rs)
                r_dec.rs = inst_code.r.rs;
            if (use_rt)
                r_dec.rt = inst_code.r.rt;
            if (use_rd)
                r_dec.rd = inst_code.r.rd;
            if (use_sa)
                r_dec.shamt = inst_code.r.shamt;
        end
    end

endmodule

// ==== id_merge.sv ====
// opcode class select, j and jal decode, immediate extension and output register
`timescale 1ns/1ps

module id_merge #(
    parameter int xlen = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  mips_isa_pkg::inst_word_t inst_code,
    input  decode_pkg::part_dec_t    i_dec,
    input  decode_pkg::part_dec_t    r_dec,
    output decode_pkg::dec_t         dec,
    output logic                     out_valid
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    logic            is_j;
    logic            is_jal;
    part_dec_t       sel;
    logic [xlen-1:0] imm_ext;
    dec_t            dec_d;

    // the record keeps the low imm_w bits of the extended value
    if (xlen < imm_w)
    begin : g_xlen_check
        $error("xlen must be at least %0d", imm_w);
    end

    assign is_jal = (inst_code.j.opcode == op_jal);
    assign is_j   = (inst_code.j.opcode == op_j) || is_jal;
    assign sel    = (inst_code.r.opcode == op_special) ? r_dec : i_dec;

    always_comb
    begin
        case (sel.imm_kind)
            imm_zero:  imm_ext = xlen'(sel.imm16);
            imm_upper: imm_ext = xlen'($signed({sel.imm16, 16'h0000}));
            default:   imm_ext = xlen'($signed(sel.imm16));
        endcase
        // word aligned jump target
        if (is_j)
            imm_ext = xlen'({inst_code.j.target26, 2'b00});
    end

    always_comb
    begin
        dec_d = '0;
        if (is_j)
        begin
            dec_d.inst = is_jal ? inst_jal : inst_j;
            // link register
            if (is_jal)
                dec_d.rd = 5'd31;
        end
        else
        begin
            dec_d.inst  = sel.inst;
            dec_d.rs    = sel.rs;
            dec_d.rt    = sel.rt;
            dec_d.rd    = sel.rd;
            dec_d.shamt = sel.shamt;
        end
        dec_d.imm = imm_ext[imm_w-1:0];
    end

    // record holds its value between strobes
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            dec       <= '0;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
                dec <= dec_d;
        end
    end

    a_valid_after_rst: assert property (@(posedge clk) rst |=> !out_valid);

    a_inst_known: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> !$isunknown(dec.inst)
    );

endmodule

// ==== decode_stage.sv ====
// top level joining the I and R decoders with the merge register
`timescale 1ns/1ps

module decode_stage #(
    parameter int xlen = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  mips_isa_pkg::inst_word_t inst_code,
    output decode_pkg::dec_t         dec,
    output logic                     out_valid
);
    import decode_pkg::*;

    part_dec_t i_dec;
    part_dec_t r_dec;

    // both decoders see every word
    id_i u_id_i (
        .inst_code (inst_code),
        .i_dec     (i_dec)
    );

    id_r u_id_r (
        .inst_code (inst_code),
        .r_dec     (r_dec)
    );

    id_merge #(
        .xlen (xlen)
    ) u_id_merge (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .inst_code (inst_code),
        .i_dec     (i_dec),
        .r_dec     (r_dec),
        .dec       (dec),
        .out_valid (out_valid)
    );

endmodule

// ==== tb_clkgen.sv ====
// free-running testbench clock source
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int period_ns = 4
) (
    output logic clk
);

    // low for the first half period
    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2.0) clk = ~clk;
    end

endmodule

// ==== tb_decode_stage.sv ====
// testbench with lfsr stimulus, reference decoder model, scoreboard queue and result line
`timescale 1ns/1ps

module tb_decode_stage;
    import mips_isa_pkg::*;
    import decode_pkg::*;

    localparam int num_words   = 2000;
    localparam int max_cycles  = 10000;
    localparam int drain_limit = 20;

    logic       clk;
    logic       rst;
    logic       in_valid;
    inst_word_t inst_code;
    dec_t       dec;
    logic       out_valid;

    logic [31:0] lfsr_state;
    dec_t        exp_q[$];
    logic        prev_valid;
    logic        seen_strobe;
    int          sent;
    int          cycles;
    int          val_errs;
    int          proto_errs;
    int          timeout_errs;

    tb_clkgen #(
        .period_ns (4)
    ) u_clkgen (
        .clk (clk)
    );

    decode_stage #(
        .xlen (32)
    ) u_decode_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .inst_code (inst_code),
        .dec       (dec),
        .out_valid (out_valid)
    );

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one lfsr step per bit drawn
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // opcode from a weighted table and fields shaped so legal words show up often
    function automatic logic [31:0] make_word();
        logic [4:0]  slot;
        logic [2:0]  shape;
        logic [31:0] w;
        slot = 5'(take_bits(5));
        w    = take_bits(32);
        case (slot)
            5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6: w[31:26] = op_special;
            5'd7, 5'd8:          w[31:26] = op_regimm;
            5'd9:                w[31:26] = op_j;
            5'd10:               w[31:26] = op_jal;
            5'd11:               w[31:26] = op_beq;
            5'd12:               w[31:26] = op_bne;
            5'd13:               w[31:26] = op_blez;
            5'd14:               w[31:26] = op_bgtz;
            5'd15:               w[31:26] = op_addiu;
            5'd16:               w[31:26] = op_slti;
            5'd17:               w[31:26] = op_sltiu;
            5'd18:               w[31:26] = op_andi;
            5'd19:               w[31:26] = op_ori;
            5'd20:               w[31:26] = op_xori;
            5'd21:               w[31:26] = op_lui;
            5'd22, 5'd23, 5'd24: w[31:26] = op_cop0;
            // memory group with a few illegal holes
            5'd25, 5'd26, 5'd27, 5'd28: w[31:26] = {2'b10, 4'(take_bits(4))};
            5'd29, 5'd30:        w[31:26] = 6'(take_bits(6));
            // addi is not part of this core
            default:             w[31:26] = 6'h08;
        endcase
        if (w[31:26] == op_special)
        begin
            case (4'(take_bits(4)))
                4'd0:    w[5:0] = funct_sll;
                4'd1:    w[5:0] = funct_srl;
                4'd2:    w[5:0] = funct_sra;
                4'd3:    w[5:0] = funct_jr;
                4'd4:    w[5:0] = funct_jalr;
                4'd5:    w[5:0] = funct_addu;
                4'd6:    w[5:0] = funct_subu;
                4'd7:    w[5:0] = funct_and;
                4'd8:    w[5:0] = funct_or;
                4'd9:    w[5:0] = funct_xor;
                4'd10:   w[5:0] = funct_nor;
                4'd11:   w[5:0] = funct_slt;
                4'd12:   w[5:0] = funct_sltu;
                default: w[5:0] = 6'(take_bits(6));
            endcase
            shape = 3'(take_bits(3));
            if (shape[0])
                w[10:6] = 5'd0;
            if (shape[1])
                w[25:21] = 5'd0;
            // rt and rd together
            if (shape[2])
                w[20:11] = 10'd0;
        end
        else if (w[31:26] == op_regimm && 2'(take_bits(2)) != 2'd0)
            w[20:16] = {4'd0, w[16]};
        else if (w[31:26] == op_cop0)
        begin
            case (2'(take_bits(2)))
                2'd0: w[25:21] = cop0_mf;
                2'd1: w[25:21] = cop0_mt;
                2'd2:
                begin
                    w[25] = 1'b1;
                    case (2'(take_bits(2)))
                        2'd0:    w[5:0] = cop0_tlbwi;
                        2'd1:    w[5:0] = cop0_tlbp;
                        2'd2:    w[5:0] = cop0_eret;
                        default: w[5:0] = cop0_wait;
                    endcase
                end
                default: ;
            endcase
        end
        return w;
    endfunction

    // reference decoder finds the identifier first and then field use and immediate kind
    function automatic dec_t ref_decode(input logic [31:0] w);
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [5:0]  fn;
        logic [15:0] imm;
        logic        ok;
        logic [3:0]  use_f;
        int          ext;
        inst_id_t    id;
        dec_t        d;
        op    = w[31:26];
        rs    = w[25:21];
        rt    = w[20:16];
        rd    = w[15:11];
        sa    = w[10:6];
        fn    = w[5:0];
        imm   = w[15:0];
        id    = inst_invalid;
        use_f = 4'b0000;
        ext   = 0;
        case (op)
            op_special:
            begin
                case (fn)
                    funct_sll:  id = inst_sll;
                    funct_srl:  id = inst_srl;
                    funct_sra:  id = inst_sra;
                    funct_jr:   id = inst_jr;
                    funct_jalr: id = inst_jalr;
                    funct_addu: id = inst_addu;
                    funct_subu: id = inst_subu;
                    funct_and:  id = inst_and;
                    funct_or:   id = inst_or;
                    funct_xor:  id = inst_xor;
                    funct_nor:  id = inst_nor;
                    funct_slt:  id = inst_slt;
                    funct_sltu: id = inst_sltu;
                    default:    id = inst_invalid;
                endcase
                // shifts need rs zero and the rest need shamt zero
                if (id == inst_sll || id == inst_srl || id == inst_sra)
                    ok = (rs == 5'd0);
                else
                    ok = (sa == 5'd0) && (id != inst_jr || (rt == 5'd0 && rd == 5'd0));
                if (!ok)
                    id = inst_invalid;
            end
            op_regimm:
            begin
                if (rt == 5'd0)
                    id = inst_bltz;
                else if (rt == 5'd1)
                    id = inst_bgez;
            end
            op_cop0:
            begin
                if (rs == 5'd0)
                    id = inst_mfc0;
                else if (rs == 5'd4)
                    id = inst_mtc0;
                else if (rs[4])
                begin
                    case (fn)
                        cop0_tlbwi: id = inst_tlbwi;
                        cop0_tlbp:  id = inst_tlbp;
                        cop0_eret:  id = inst_eret;
                        cop0_wait:  id = inst_wait;
                        default:    id = inst_invalid;
                    endcase
                end
            end
            op_j:     id = inst_j;
            op_jal:   id = inst_jal;
            op_beq:   id = inst_beq;
            op_bne:   id = inst_bne;
            op_blez:  id = inst_blez;
            op_bgtz:  id = inst_bgtz;
            op_addiu: id = inst_addiu;
            op_slti:  id = inst_slti;
            op_sltiu: id = inst_sltiu;
            op_andi:  id = inst_andi;
            op_ori:   id = inst_ori;
            op_xori:  id = inst_xori;
            op_lui:   id = inst_lui;
            op_lb:    id = inst_lb;
            op_lh:    id = inst_lh;
            op_lwl:   id = inst_lwl;
            op_lw:    id = inst_lw;
            op_lbu:   id = inst_lbu;
            op_lhu:   id = inst_lhu;
            op_lwr:   id = inst_lwr;
            op_sb:    id = inst_sb;
            op_sh:    id = inst_sh;
            op_swl:   id = inst_swl;
            op_sw:    id = inst_sw;
            op_swr:   id = inst_swr;
            default:  id = inst_invalid;
        endcase
        // use_f bits are rs rt rd shamt
        // ext 1 is sign, 2 zero, 3 upper and 4 jump target
        case (id)
            inst_sll, inst_srl, inst_sra: use_f = 4'b0111;
            inst_jr:                      use_f = 4'b1000;
            inst_jalr:                    use_f = 4'b1010;
            inst_addu, inst_subu, inst_and, inst_or, inst_xor, inst_nor,
            inst_slt, inst_sltu:          use_f = 4'b1110;
            inst_mfc0, inst_mtc0:         use_f = 4'b0110;
            inst_bltz, inst_bgez, inst_blez, inst_bgtz:
            begin
                use_f = 4'b1000;
                ext   = 1;
            end
            inst_beq, inst_bne, inst_addiu, inst_slti, inst_sltiu,
            inst_lb, inst_lh, inst_lwl, inst_lw, inst_lbu, inst_lhu, inst_lwr,
            inst_sb, inst_sh, inst_swl, inst_sw, inst_swr:
            begin
                use_f = 4'b1100;
                ext   = 1;
            end
            inst_andi, inst_ori, inst_xori:
            begin
                use_f = 4'b1100;
                ext   = 2;
            end
            inst_lui:
            begin
                use_f = 4'b0100;
                ext   = 3;
            end
            inst_j, inst_jal: ext = 4;
            default: ;
        endcase
        d      = '0;
        d.inst = id;
        if (use_f[3])
            d.rs = rs;
        if (use_f[2])
            d.rt = rt;
        if (use_f[1])
            d.rd = rd;
        if (use_f[0])
            d.shamt = sa;
        case (ext)
            1:       d.imm = {{16{imm[15]}}, imm};
            2:       d.imm = {16'h0000, imm};
            3:       d.imm = {imm, 16'h0000};
            4:       d.imm = {4'h0, w[25:0], 2'b00};
            default: d.imm = '0;
        endcase
        // link register
        if (id == inst_jal)
            d.rd = 5'd31;
        return d;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            val_errs++;
            $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // runs 1 ns after each rising edge when outputs are settled
    task automatic check_outputs();
        dec_t exp;
        check_field("out_valid", 64'(out_valid), 64'(prev_valid));
        if (!seen_strobe)
            check_field("dec", 64'(dec), 64'd0);
        if (out_valid === 1'b1)
        begin
            assert (exp_q.size() > 0)
            else
            begin
                proto_errs++;
                $display("out_valid was high at %0t with no word outstanding", $time);
            end
            if (exp_q.size() > 0)
            begin
                exp = exp_q.pop_front();
                check_field("dec.inst", 64'(dec.inst), 64'(exp.inst));
                check_field("dec.rs", 64'(dec.rs), 64'(exp.rs));
                check_field("dec.rt", 64'(dec.rt), 64'(exp.rt));
                check_field("dec.rd", 64'(dec.rd), 64'(exp.rd));
                check_field("dec.shamt", 64'(dec.shamt), 64'(exp.shamt));
                check_field("dec.imm", 64'(dec.imm), 64'(exp.imm));
            end
        end
    endtask

    // strobe about 3 cycles in 4 with noise on inst_code in idle cycles
    task automatic drive_cycle();
        logic [31:0] w;
        in_valid = (2'(take_bits(2)) != 2'd0);
        if (in_valid)
        begin
            w = make_word();
            exp_q.push_back(ref_decode(w));
            sent++;
            seen_strobe = 1'b1;
        end
        else
            w = take_bits(32);
        inst_code  = w;
        prev_valid = in_valid;
    endtask

    initial
    begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        inst_code    = '0;
        lfsr_state   = 32'd9004;
        prev_valid   = 1'b0;
        seen_strobe  = 1'b0;
        sent         = 0;
        val_errs     = 0;
        proto_errs   = 0;
        timeout_errs = 0;

        repeat (2)
        begin
            @(posedge clk);
            #1;
            check_outputs();
        end
        rst = 1'b0;

        // record must stay zero over a few quiet cycles
        repeat (3)
        begin
            @(posedge clk);
            #1;
            check_outputs();
        end

        cycles = 0;
        while (sent < num_words && cycles < max_cycles)
        begin
            @(posedge clk);
            #1;
            check_outputs();
            drive_cycle();
            cycles++;
        end
        assert (sent == num_words)
        else
        begin
            timeout_errs++;
            $display("only %0d words were sent within %0d cycles", sent, max_cycles);
        end

        cycles = 0;
        while (exp_q.size() != 0 && cycles < drain_limit)
        begin
            @(posedge clk);
            #1;
            check_outputs();
            in_valid   = 1'b0;
            prev_valid = 1'b0;
            cycles++;
        end
        assert (exp_q.size() == 0)
        else
        begin
            timeout_errs++;
            $display("%0d results still missing after %0d cycles", exp_q.size(), drain_limit);
        end

        // nothing may follow the last result
        repeat (3)
        begin
            @(posedge clk);
            #1;
            check_outputs();
        end

        $display("errors: %0d value, %0d protocol, %0d timeout, %0d words sent",
                 val_errs, proto_errs, timeout_errs, sent);
        if (val_errs + proto_errs + timeout_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
mips_isa_pkg.sv
decode_pkg.sv
id_i.sv
id_r.sv
id_merge.sv
decode_stage.sv
tb_clkgen.sv
tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  # packages first, then the decoders and the top level
  - mips_isa_pkg.sv
  - decode_pkg.sv
  - id_i.sv
  - id_r.sv
  - id_merge.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_decode_stage.sv
